//--- adc_pkg.sv
// multislope adc shared definitions

package adc_pkg;

  ////////////////////////////////////////////////////////////
  // widths with a meaning

  // tally or register value as seen on the serial port
  typedef logic [23:0] count_t;
  // phase and integration clock counts need more than 24 bits
  typedef logic [31:0] wide_count_t;
  typedef logic [2:0]  flip_t;
  // {sig, neg ref, pos ref} integrator input switches
  typedef logic [2:0]  sw_code_t;
  typedef logic [7:0]  addr_t;

  ////////////////////////////////////////////////////////////
  // integrator switch codes

  localparam sw_code_t sw_off     = 3'b000;
  // positive ref in so the integrator walks down
  localparam sw_code_t sw_pos     = 3'b101;
  // negative ref in so the integrator walks up
  localparam sw_code_t sw_neg     = 3'b110;
  // both refs on for a small bias in the slow rundown
  localparam sw_code_t sw_rundown = 3'b011;

  ////////////////////////////////////////////////////////////
  // register map

  localparam addr_t addr_test       = 8'd7;
  localparam addr_t addr_up         = 8'd9;
  localparam addr_t addr_down       = 8'd10;
  localparam addr_t addr_rundown    = 8'd11;
  localparam addr_t addr_trans_up   = 8'd12;
  localparam addr_t addr_trans_down = 8'd14;
  // fixed pattern to check the link
  localparam addr_t addr_ident      = 8'd15;
  localparam addr_t addr_dir        = 8'd16;
  localparam addr_t addr_flip       = 8'd17;

  // sequencer states with a one cycle start state per phase
  typedef enum logic [3:0] {
    init_start, init,
    fix_pos_start, fix_pos,
    var_start, var1,
    fix_neg_start, fix_neg,
    var2_start, var2,
    rundown_start, rundown,
    done
  } seq_state_t;

endpackage

//--- phase_timer.sv
// phase and integration timers

`timescale 1ns/1ns

module phase_timer #(
  parameter int init_cycles = 10000,
  parameter int fix_cycles  = 1000,
  parameter int var_cycles  = 7000,
  parameter int int_cycles  = 4000000
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                phase_clear,
  input  logic                tot_clear,
  output adc_pkg::wide_count_t phase_count,
  output logic                init_end,
  output logic                fix_end,
  output logic                var_end,
  output logic                int_end
);

  // clocks since the start of signal integration
  adc_pkg::wide_count_t tot_count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase_count <= '0;
      tot_count   <= '0;
    end
    else
    begin
      // phase count restarts on every phase start cycle
      if (phase_clear)
        phase_count <= '0;
      else
        phase_count <= phase_count + 1'b1;
      // integration count holds once the minimum time is reached, no wrap
      if (tot_clear)
        tot_count <= '0;
      else if (!int_end)
        tot_count <= tot_count + 1'b1;
    end
  end

  // init counts one extra cycle, a pause for reads and settling
  assign init_end = (phase_count == adc_pkg::wide_count_t'(init_cycles));
  // fixed and variable phases last exactly their length after the start cycle
  assign fix_end  = (phase_count == adc_pkg::wide_count_t'(fix_cycles - 1));
  assign var_end  = (phase_count == adc_pkg::wide_count_t'(var_cycles - 1));
  assign int_end  = (tot_count >= adc_pkg::wide_count_t'(int_cycles));

endmodule

//--- modulation_ctrl.sv
// multislope modulation sequencer

`timescale 1ns/1ns

module modulation_ctrl (
  input  logic             clk,
  input  logic             rst,
  // 1 means integrator below the zero cross
  input  logic             cmpr_out,
  input  logic             init_end,
  input  logic             fix_end,
  input  logic             var_end,
  input  logic             int_end,
  output adc_pkg::sw_code_t int_sw,
  // active low conversion done
  output logic             com_int_n,
  output logic             phase_clear,
  output logic             tot_clear,
  output logic             tally_clear,
  output logic             decide_valid,
  output logic             decide_up,
  output logic             flip_inc,
  output logic             latch_results,
  output adc_pkg::sw_code_t sw_next
);

  adc_pkg::seq_state_t state;
  adc_pkg::seq_state_t state_next;

  // comparator sync chain with the synchronized value in stage 1
  logic [2:0] cmpr_q;
  logic       cmpr_sync;
  logic       zero_cross;

  ////////////////////////////////////////////////////////////
  // comparator synchronizer and zero cross detect

  always_ff @(posedge clk)
  begin
    cmpr_q <= {cmpr_q[1:0], cmpr_out};
  end

  assign cmpr_sync  = cmpr_q[1];
  // either direction of crossing ends the rundown
  assign zero_cross = cmpr_q[1] ^ cmpr_q[2];
  assign decide_up  = cmpr_sync;

  ////////////////////////////////////////////////////////////
  // phase sequencing

  always_comb
  begin
    state_next    = state;
    sw_next       = int_sw;
    phase_clear   = 1'b0;
    tot_clear     = 1'b0;
    tally_clear   = 1'b0;
    decide_valid  = 1'b0;
    flip_inc      = 1'b0;
    latch_results = 1'b0;
    case (state)
      adc_pkg::init_start:
      begin
        // integration time of a new conversion starts here
        phase_clear = 1'b1;
        tot_clear   = 1'b1;
        tally_clear = 1'b1;
        state_next  = adc_pkg::init;
      end
      adc_pkg::init:
        if (init_end)
          state_next = adc_pkg::fix_pos_start;
      adc_pkg::fix_pos_start:
      begin
        phase_clear = 1'b1;
        sw_next     = adc_pkg::sw_pos;
        state_next  = adc_pkg::fix_pos;
      end
      adc_pkg::fix_pos:
        if (fix_end)
          state_next = adc_pkg::var_start;
      adc_pkg::var_start,
      adc_pkg::var2_start:
      begin
        // below the zero cross drives up and above drives down
        phase_clear  = 1'b1;
        decide_valid = 1'b1;
        sw_next      = cmpr_sync ? adc_pkg::sw_neg : adc_pkg::sw_pos;
        state_next   = (state == adc_pkg::var_start) ? adc_pkg::var1 : adc_pkg::var2;
      end
      adc_pkg::var1:
        if (var_end)
          state_next = adc_pkg::fix_neg_start;
      adc_pkg::fix_neg_start:
      begin
        phase_clear = 1'b1;
        sw_next     = adc_pkg::sw_neg;
        state_next  = adc_pkg::fix_neg;
      end
      adc_pkg::fix_neg:
        if (fix_end)
          state_next = adc_pkg::var2_start;
      adc_pkg::var2:
        if (var_end)
        begin
          if (!int_end)
            state_next = adc_pkg::fix_pos_start;
          else if (cmpr_sync)
          begin
            // wrong side for the rundown so one more variable phase
            flip_inc   = 1'b1;
            state_next = adc_pkg::var2_start;
          end
          else
            state_next = adc_pkg::rundown_start;
        end
      adc_pkg::rundown_start:
      begin
        phase_clear = 1'b1;
        sw_next     = adc_pkg::sw_rundown;
        state_next  = adc_pkg::rundown;
      end
      adc_pkg::rundown:
        if (zero_cross)
        begin
          // first crossing turns the inputs off and captures the results
          sw_next       = adc_pkg::sw_off;
          latch_results = 1'b1;
          state_next    = adc_pkg::done;
        end
      adc_pkg::done:
        state_next = adc_pkg::init_start;
      default:
        state_next = adc_pkg::init_start;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= adc_pkg::init_start;
      int_sw    <= adc_pkg::sw_off;
      com_int_n <= 1'b1;
    end
    else
    begin
      state     <= state_next;
      int_sw    <= sw_next;
      // low for the single cycle in done
      com_int_n <= ~latch_results;
    end
  end

endmodule

//--- count_tally.sv
// modulation tallies and result latches

`timescale 1ns/1ns

module count_tally (
  input  logic                clk,
  input  logic                rst,
  input  logic                tally_clear,
  input  logic                decide_valid,
  input  logic                decide_up,
  input  logic                flip_inc,
  input  adc_pkg::sw_code_t    sw_next,
  input  logic                latch_results,
  input  adc_pkg::wide_count_t phase_count,
  output adc_pkg::count_t      up_last,
  output adc_pkg::count_t      down_last,
  output adc_pkg::count_t      trans_up_last,
  output adc_pkg::count_t      trans_down_last,
  output adc_pkg::count_t      rundown_last,
  output logic                dir_last,
  output adc_pkg::flip_t       flip_last
);

  // local copy of the code driving the integrator
  adc_pkg::sw_code_t cur_sw;

  // running tallies for the conversion in progress
  adc_pkg::count_t up_cnt;
  adc_pkg::count_t down_cnt;
  adc_pkg::count_t trans_up_cnt;
  adc_pkg::count_t trans_down_cnt;
  adc_pkg::flip_t  flip_cnt;

  logic trans_up;
  logic trans_down;

  // a change of code onto a ref counts as a transition in that direction
  assign trans_up   = (sw_next != cur_sw) && (sw_next == adc_pkg::sw_neg);
  assign trans_down = (sw_next != cur_sw) && (sw_next == adc_pkg::sw_pos);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      cur_sw          <= adc_pkg::sw_off;
      up_cnt          <= '0;
      down_cnt        <= '0;
      trans_up_cnt    <= '0;
      trans_down_cnt  <= '0;
      flip_cnt        <= '0;
      up_last         <= '0;
      down_last       <= '0;
      trans_up_last   <= '0;
      trans_down_last <= '0;
      rundown_last    <= '0;
      dir_last        <= 1'b0;
      flip_last       <= '0;
    end
    else
    begin
      cur_sw <= sw_next;
      if (tally_clear)
      begin
        up_cnt         <= '0;
        down_cnt       <= '0;
        trans_up_cnt   <= '0;
        trans_down_cnt <= '0;
        flip_cnt       <= '0;
      end
      else
      begin
        if (decide_valid && decide_up)
          up_cnt <= up_cnt + 1'b1;
        if (decide_valid && !decide_up)
          down_cnt <= down_cnt + 1'b1;
        if (trans_up)
          trans_up_cnt <= trans_up_cnt + 1'b1;
        if (trans_down)
          trans_down_cnt <= trans_down_cnt + 1'b1;
        if (flip_inc)
          flip_cnt <= flip_cnt + 1'b1;
      end
      // results held until the next conversion ends
      if (latch_results)
      begin
        up_last         <= up_cnt;
        down_last       <= down_cnt;
        trans_up_last   <= trans_up_cnt;
        trans_down_last <= trans_down_cnt;
        // rundown length in clocks, low 24 bits
        rundown_last    <= adc_pkg::count_t'(phase_count);
        // set only if the rundown drove the integrator up
        dir_last        <= (cur_sw == adc_pkg::sw_neg);
        flip_last       <= flip_cnt;
      end
    end
  end

endmodule

//--- spi_reg_bank.sv
// serial register port

`timescale 1ns/1ns

module spi_reg_bank (
  input  logic           clk,
  input  logic           rst,
  input  logic           sclk,
  input  logic           cs_n,
  input  logic           mosi,
  output logic           miso,
  input  adc_pkg::count_t up_last,
  input  adc_pkg::count_t down_last,
  input  adc_pkg::count_t trans_up_last,
  input  adc_pkg::count_t trans_down_last,
  input  adc_pkg::count_t rundown_last,
  input  logic           dir_last,
  input  adc_pkg::flip_t  flip_last
);

  // 8 bit address then 24 bit value
  localparam int frame_bits = $bits(adc_pkg::addr_t) + $bits(adc_pkg::count_t);

  ////////////////////////////////////////////////////////////
  // pin synchronizers with a third stage for edge detect

  logic [2:0] sclk_q;
  logic [2:0] cs_q;
  logic [1:0] mosi_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sclk_q <= '0;
      cs_q   <= '1;
      mosi_q <= '0;
    end
    else
    begin
      sclk_q <= {sclk_q[1:0], sclk};
      cs_q   <= {cs_q[1:0], cs_n};
      mosi_q <= {mosi_q[0], mosi};
    end
  end

  logic sclk_rise;
  logic sclk_fall;
  logic cs_fall;
  logic cs_rise;

  assign sclk_rise = sclk_q[1] & ~sclk_q[2] & ~cs_q[1];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2] & ~cs_q[1];
  assign cs_fall   = ~cs_q[1] & cs_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];

  ////////////////////////////////////////////////////////////
  // frame shift and readback

  logic [frame_bits-1:0] shift_in;
  adc_pkg::count_t       shift_out;
  adc_pkg::count_t       test_reg;
  adc_pkg::count_t       readback;
  adc_pkg::addr_t        addr_next;
  logic [5:0]            bit_cnt;

  // address byte as it completes on the 8th rise
  assign addr_next = {shift_in[6:0], mosi_q[1]};

  // bit 7 only blocks the write and is ignored here
  always_comb
  begin
    case ({1'b0, addr_next[6:0]})
      adc_pkg::addr_test:       readback = test_reg;
      adc_pkg::addr_up:         readback = up_last;
      adc_pkg::addr_down:       readback = down_last;
      adc_pkg::addr_rundown:    readback = rundown_last;
      adc_pkg::addr_trans_up:   readback = trans_up_last;
      adc_pkg::addr_trans_down: readback = trans_down_last;
      adc_pkg::addr_ident:      readback = 24'hffffff;
      adc_pkg::addr_dir:        readback = adc_pkg::count_t'(dir_last);
      adc_pkg::addr_flip:       readback = adc_pkg::count_t'(flip_last);
      default:                  readback = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      bit_cnt   <= '0;
      shift_out <= '0;
      miso      <= 1'b0;
      test_reg  <= '0;
    end
    else if (cs_fall)
    begin
      // new frame keeps miso quiet through the address byte
      bit_cnt   <= '0;
      shift_out <= '0;
      miso      <= 1'b0;
    end
    else if (cs_rise)
    begin
      miso <= 1'b0;
      // write only on a full frame to the test register
      if (bit_cnt == 6'(frame_bits) && shift_in[frame_bits-1 -: 8] == adc_pkg::addr_test)
        test_reg <= shift_in[23:0];
    end
    else if (sclk_rise)
    begin
      if (bit_cnt != '1)
        bit_cnt <= bit_cnt + 1'b1;
      if (bit_cnt == 6'd7)
        shift_out <= readback;
    end
    else if (sclk_fall)
    begin
      // next bit out msb first on each fall
      miso      <= shift_out[23];
      shift_out <= shift_out << 1;
    end
  end

  // incoming frame shifted in msb first
  always_ff @(posedge clk)
  begin
    if (sclk_rise)
      shift_in <= {shift_in[frame_bits-2:0], mosi_q[1]};
  end

endmodule

//--- adc_top.sv
// multislope adc front end top level

`timescale 1ns/1ns

module adc_top #(
  parameter int init_cycles = 10000,
  parameter int fix_cycles  = 1000,
  parameter int var_cycles  = 7000,
  parameter int int_cycles  = 4000000
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             cmpr_out,
  output adc_pkg::sw_code_t int_sw,
  output logic             com_int_n,
  input  logic             sclk,
  input  logic             cs_n,
  input  logic             mosi,
  output logic             miso
);

  // sequencer to timer
  adc_pkg::wide_count_t phase_count;
  logic phase_clear;
  logic tot_clear;
  logic init_end;
  logic fix_end;
  logic var_end;
  logic int_end;

  // sequencer to tallies
  logic tally_clear;
  logic decide_valid;
  logic decide_up;
  logic flip_inc;
  logic latch_results;
  adc_pkg::sw_code_t sw_next;

  // latched results to the register port
  adc_pkg::count_t up_last;
  adc_pkg::count_t down_last;
  adc_pkg::count_t trans_up_last;
  adc_pkg::count_t trans_down_last;
  adc_pkg::count_t rundown_last;
  logic           dir_last;
  adc_pkg::flip_t  flip_last;

  phase_timer #(
    .init_cycles(init_cycles),
    .fix_cycles (fix_cycles),
    .var_cycles (var_cycles),
    .int_cycles (int_cycles)
  ) i_timer (
    .clk(clk), .rst(rst), .phase_clear(phase_clear), .tot_clear(tot_clear),
    .phase_count(phase_count), .init_end(init_end), .fix_end(fix_end),
    .var_end(var_end), .int_end(int_end)
  );

  modulation_ctrl i_ctrl (
    .clk(clk), .rst(rst), .cmpr_out(cmpr_out),
    .init_end(init_end), .fix_end(fix_end), .var_end(var_end), .int_end(int_end),
    .int_sw(int_sw), .com_int_n(com_int_n),
    .phase_clear(phase_clear), .tot_clear(tot_clear), .tally_clear(tally_clear),
    .decide_valid(decide_valid), .decide_up(decide_up), .flip_inc(flip_inc),
    .latch_results(latch_results), .sw_next(sw_next)
  );

  count_tally i_tally (
    .clk(clk), .rst(rst), .tally_clear(tally_clear),
    .decide_valid(decide_valid), .decide_up(decide_up), .flip_inc(flip_inc),
    .sw_next(sw_next), .latch_results(latch_results), .phase_count(phase_count),
    .up_last(up_last), .down_last(down_last),
    .trans_up_last(trans_up_last), .trans_down_last(trans_down_last),
    .rundown_last(rundown_last), .dir_last(dir_last), .flip_last(flip_last)
  );

  spi_reg_bank i_regs (
    .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .up_last(up_last), .down_last(down_last),
    .trans_up_last(trans_up_last), .trans_down_last(trans_down_last),
    .rundown_last(rundown_last), .dir_last(dir_last), .flip_last(flip_last)
  );

endmodule

//--- adc_checker.sv
// multislope adc checker, phase model and tallies

`timescale 1ns/1ns

module adc_checker #(
  parameter int init_cycles = 20,
  parameter int fix_cycles  = 6,
  parameter int var_cycles  = 10,
  parameter int int_cycles  = 100
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmpr_out,
  input  adc_pkg::sw_code_t int_sw,
  input  logic              com_int_n,
  input  logic              cs_n,
  input  logic              miso,
  // one pulse per finished serial frame
  input  logic              acc_valid,
  input  adc_pkg::addr_t    acc_addr,
  input  adc_pkg::count_t   acc_wdata,
  input  adc_pkg::count_t   acc_rdata,
  input  adc_pkg::flip_t    row_flips,
  output int                err_count,
  output int                check_count
);

  // model phases, start cycles kept apart like the sequencer
  localparam int ph_init_start = 0;
  localparam int ph_init       = 1;
  localparam int ph_fix_pos_s  = 2;
  localparam int ph_fix_pos    = 3;
  localparam int ph_var_s      = 4;
  localparam int ph_var        = 5;
  localparam int ph_fix_neg_s  = 6;
  localparam int ph_fix_neg    = 7;
  localparam int ph_var2_s     = 8;
  localparam int ph_var2       = 9;
  localparam int ph_rund_s     = 10;
  localparam int ph_rund       = 11;
  localparam int ph_done       = 12;

  int ph;
  // cycle in phase, and cycles since integration start
  int n;
  int t;
  logic q0;
  logic q1;
  logic q2;
  logic frame_seen;
  adc_pkg::sw_code_t exp_sw;
  logic exp_int_n;
  adc_pkg::count_t up;
  adc_pkg::count_t down;
  adc_pkg::count_t tu;
  adc_pkg::count_t td;
  adc_pkg::flip_t  flips;
  adc_pkg::count_t e_up;
  adc_pkg::count_t e_down;
  adc_pkg::count_t e_tu;
  adc_pkg::count_t e_td;
  adc_pkg::count_t e_rd;
  adc_pkg::flip_t  e_flip;
  adc_pkg::count_t test_model;

  initial
  begin
    err_count   = 0;
    check_count = 0;
  end

  task automatic check(input logic ok, input string msg);
    check_count++;
    if (!ok)
    begin
      err_count++;
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
    end
  endtask

  // register map as seen from the serial port, bit 7 only blocks writes
  function automatic adc_pkg::count_t expected_read(input adc_pkg::addr_t a);
    adc_pkg::addr_t low;
    low = {1'b0, a[6:0]};
    if (low == adc_pkg::addr_test)            return test_model;
    else if (low == adc_pkg::addr_up)         return e_up;
    else if (low == adc_pkg::addr_down)       return e_down;
    else if (low == adc_pkg::addr_rundown)    return e_rd;
    else if (low == adc_pkg::addr_trans_up)   return e_tu;
    else if (low == adc_pkg::addr_trans_down) return e_td;
    else if (low == adc_pkg::addr_ident)      return 24'hffffff;
    else if (low == adc_pkg::addr_flip)       return adc_pkg::count_t'(e_flip);
    return '0;
  endfunction

  // comparator as the two flop synchronizer sees it
  always @(posedge clk)
  begin
    q0 <= cmpr_out;
    q1 <= q0;
    q2 <= q1;
    if (rst)
      frame_seen <= 1'b0;
    else if (!cs_n)
      frame_seen <= 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // phase model, compares int_sw and com_int_n every cycle

  always @(posedge clk)
  begin : model
    adc_pkg::sw_code_t nsw;
    if (rst)
    begin
      ph         <= ph_init_start;
      exp_sw     <= adc_pkg::sw_off;
      exp_int_n  <= 1'b1;
      {up, down, tu, td, flips} <= '0;
      {e_up, e_down, e_tu, e_td, e_rd, e_flip} <= '0;
      test_model <= '0;
    end
    else
    begin
      check(int_sw === exp_sw,
            $sformatf("int_sw %b, expected %b in phase %0d", int_sw, exp_sw, ph));
      check(com_int_n === exp_int_n,
            $sformatf("com_int_n %b, expected %b", com_int_n, exp_int_n));
      if (!frame_seen)
        check(miso === 1'b0, "miso not low before the first frame");
      nsw = exp_sw;
      exp_int_n <= 1'b1;
      t <= t + 1;
      case (ph)
        ph_init_start:
        begin
          {up, down, tu, td, flips} <= '0;
          n  <= 0;
          t  <= 0;
          ph <= ph_init;
        end
        ph_init:
          if (n == init_cycles)
            ph <= ph_fix_pos_s;
          else
            n <= n + 1;
        ph_fix_pos_s, ph_fix_neg_s:
        begin
          nsw = (ph == ph_fix_pos_s) ? adc_pkg::sw_pos : adc_pkg::sw_neg;
          n  <= 0;
          ph <= ph + 1;
        end
        ph_fix_pos, ph_fix_neg:
          if (n == fix_cycles - 1)
            ph <= ph + 1;
          else
            n <= n + 1;
        ph_var_s, ph_var2_s:
        begin
          // below zero cross pushes the integrator up
          nsw = q1 ? adc_pkg::sw_neg : adc_pkg::sw_pos;
          if (q1)
            up <= up + 1'b1;
          else
            down <= down + 1'b1;
          n  <= 0;
          ph <= ph + 1;
        end
        ph_var:
          if (n == var_cycles - 1)
            ph <= ph_fix_neg_s;
          else
            n <= n + 1;
        ph_var2:
          if (n != var_cycles - 1)
            n <= n + 1;
          else if (t < int_cycles)
            ph <= ph_fix_pos_s;
          else if (q1)
          begin
            flips <= flips + 1'b1;
            ph    <= ph_var2_s;
          end
          else
            ph <= ph_rund_s;
        ph_rund_s:
        begin
          nsw = adc_pkg::sw_rundown;
          n  <= 0;
          ph <= ph_rund;
        end
        ph_rund:
          if (q1 !== q2)
          begin
            nsw = adc_pkg::sw_off;
            exp_int_n <= 1'b0;
            e_up   <= up;
            e_down <= down;
            e_tu   <= tu;
            e_td   <= td;
            e_rd   <= adc_pkg::count_t'(n);
            e_flip <= flips;
            ph     <= ph_done;
          end
          else
            n <= n + 1;
        default:
          ph <= ph_init_start;
      endcase
      // transitions onto a reference
      if (nsw != exp_sw && nsw == adc_pkg::sw_neg)
        tu <= tu + 1'b1;
      if (nsw != exp_sw && nsw == adc_pkg::sw_pos)
        td <= td + 1'b1;
      exp_sw <= nsw;

      ////////////////////////////////////////////////////////////
      // serial frames

      if (acc_valid)
      begin
        check(acc_rdata === expected_read(acc_addr),
              $sformatf("read of %h gave %h, expected %h",
                        acc_addr, acc_rdata, expected_read(acc_addr)));
        if (acc_addr[6:0] == adc_pkg::addr_flip[6:0])
          check(acc_rdata === adc_pkg::count_t'(row_flips),
                $sformatf("flip count %0d, row asked for %0d", acc_rdata, row_flips));
        if (acc_addr == adc_pkg::addr_test)
          test_model <= acc_wdata;
      end
    end
  end

endmodule

//--- tb_adc.sv
// multislope adc testbench

`timescale 1ns/1ns

module tb_adc;

  localparam int init_cycles = 20;
  localparam int fix_cycles  = 6;
  localparam int var_cycles  = 10;
  localparam int int_cycles  = 100;
  // clk cycles per sclk half period
  localparam int half_bit    = 6;
  localparam int frame_cyc   = half_bit * 68 + 1;
  localparam int num_rows    = 5;

  logic clk = 1'b0;
  logic rst;
  logic cmpr_out;
  logic sclk;
  logic cs_n;
  logic mosi;
  logic miso;
  logic com_int_n;
  adc_pkg::sw_code_t int_sw;
  logic acc_valid;
  adc_pkg::addr_t  acc_addr;
  adc_pkg::count_t acc_wdata;
  adc_pkg::count_t acc_rdata;
  adc_pkg::flip_t  row_flips;
  int err_count;
  int check_count;
  logic [31:0] lfsr;
  int cycles = 0;
  int cycle_limit;
  adc_pkg::count_t rd;

  // stimulus rows, mode 0 all low, 1 all high, 2 lfsr
  int row_mode [num_rows] = '{0, 1, 2, 2, 1};
  int row_flip [num_rows] = '{0, 2, 0, 1, 3};
  int row_delay[num_rows] = '{3, 5, 7, 4, 9};

  always #2 clk = ~clk;

  adc_top #(
    .init_cycles(init_cycles),
    .fix_cycles (fix_cycles),
    .var_cycles (var_cycles),
    .int_cycles (int_cycles)
  ) i_dut (
    .clk(clk), .rst(rst), .cmpr_out(cmpr_out), .int_sw(int_sw),
    .com_int_n(com_int_n), .sclk(sclk), .cs_n(cs_n), .mosi(mosi), .miso(miso)
  );

  adc_checker #(
    .init_cycles(init_cycles),
    .fix_cycles (fix_cycles),
    .var_cycles (var_cycles),
    .int_cycles (int_cycles)
  ) i_checker (
    .clk(clk), .rst(rst), .cmpr_out(cmpr_out), .int_sw(int_sw),
    .com_int_n(com_int_n), .cs_n(cs_n), .miso(miso), .acc_valid(acc_valid),
    .acc_addr(acc_addr), .acc_wdata(acc_wdata), .acc_rdata(acc_rdata),
    .row_flips(row_flips), .err_count(err_count), .check_count(check_count)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // first fix_pos cycle to the var2 cycle that ends run-up
  function automatic int runup_end();
    int k;
    k = 2 * fix_cycles + 2 * var_cycles + 2;
    while (init_cycles + 2 + k < int_cycles)
      k += 2 * fix_cycles + 2 * var_cycles + 4;
    return k;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // full 32 bit frame, address byte then value, msb first
  task automatic serial_frame(input adc_pkg::addr_t addr, input adc_pkg::count_t wdata,
                              output adc_pkg::count_t rdata);
    logic [31:0] frame;
    frame = {addr, wdata};
    rdata = '0;
    cs_n  = 1'b0;
    repeat (half_bit) next_cycle();
    for (int i = 31; i >= 0; i--)
    begin
      mosi = frame[i];
      sclk = 1'b0;
      repeat (half_bit) next_cycle();
      if (i < 24)
        rdata = {rdata[22:0], miso};
      sclk = 1'b1;
      repeat (half_bit) next_cycle();
    end
    sclk = 1'b0;
    repeat (half_bit) next_cycle();
    cs_n = 1'b1;
    repeat (2 * half_bit) next_cycle();
    // hand the frame to the checker
    acc_addr  = addr;
    acc_wdata = wdata;
    acc_rdata = rdata;
    acc_valid = 1'b1;
    next_cycle();
    acc_valid = 1'b0;
  endtask

  // end whatever conversion is running with a crossing
  task automatic flush_conversion();
    cmpr_out = 1'b0;
    next_cycle();
    while (int_sw != adc_pkg::sw_rundown)
      next_cycle();
    repeat (3) next_cycle();
    cmpr_out = 1'b1;
    while (com_int_n)
      next_cycle();
  endtask

  task automatic run_row(input int mode, input int flips, input int delay);
    int k_end;
    logic b;
    k_end = runup_end();
    flush_conversion();
    while (int_sw != adc_pkg::sw_pos)
      next_cycle();
    // comparator changes well before each variable start
    for (int k = 1; k <= k_end + (var_cycles + 1) * flips; k++)
    begin
      next_cycle();
      if (k < k_end - 6 && k >= fix_cycles - 4 &&
          (k - (fix_cycles - 4)) % (fix_cycles + var_cycles + 2) == 0)
      begin
        b = lfsr[0];
        if (mode == 2)
          lfsr = lfsr_next(lfsr);
        cmpr_out = (mode == 2) ? b : (mode == 1);
      end
      if (k == k_end - 6)
        cmpr_out = (flips > 0);
      if (flips > 0 && k == k_end + (var_cycles + 1) * flips - 5)
        cmpr_out = 1'b0;
    end
    while (int_sw != adc_pkg::sw_rundown)
      next_cycle();
    repeat (delay) next_cycle();
    cmpr_out = 1'b1;
    while (com_int_n)
      next_cycle();
    row_flips = adc_pkg::flip_t'(flips);
    serial_frame(adc_pkg::addr_up | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_down | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_rundown | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_trans_up | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_trans_down | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_dir | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_flip | 8'h80, '0, rd);
  endtask

  ////////////////////////////////////////////////////////////
  // timeout

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("timeout: no end of test after %0d cycles", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial
  begin
    rst       = 1'b1;
    cmpr_out  = 1'b0;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    acc_valid = 1'b0;
    acc_addr  = '0;
    acc_wdata = '0;
    acc_rdata = '0;
    row_flips = '0;
    lfsr      = 32'h688d;
    // two conversions per row plus all serial frames, doubled
    cycle_limit = (7 * num_rows + 4) * frame_cyc + 200;
    for (int r = 0; r < num_rows; r++)
      cycle_limit += 2 * (init_cycles + runup_end() + 24 +
                          (var_cycles + 1) * row_flip[r] + row_delay[r]);
    cycle_limit = 2 * cycle_limit;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    serial_frame(adc_pkg::addr_ident | 8'h80, '0, rd);
    serial_frame(adc_pkg::addr_test, 24'h5a3c96, rd);
    // bit 7 set, the value sent must not land
    serial_frame(adc_pkg::addr_test | 8'h80, 24'h123456, rd);
    serial_frame(adc_pkg::addr_test | 8'h80, '0, rd);
    for (int r = 0; r < num_rows; r++)
      run_row(row_mode[r], row_flip[r], row_delay[r]);
    repeat (10) next_cycle();
    $display("errors: %0d of %0d checks", err_count, check_count);
    if (err_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- multislope_adc.f
adc_pkg.sv
phase_timer.sv
modulation_ctrl.sv
count_tally.sv
spi_reg_bank.sv
adc_top.sv
adc_checker.sv
tb_adc.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f multislope_adc.f --top-module tb_adc -o tb_adc_sim
./obj_dir/tb_adc_sim > sim.log
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
grep -q "RESULT: PASS" sim.log
